//--- sim.f
+incdir+include
verilog/pkt_extract_pkg.sv
verilog/pkt_capture.sv
verilog/pkt_slot.sv
verilog/mac_tx.sv
verilog/pkt_extract_top.sv
sim/pkt_extract_assertions.sv
sim/pkt_extract_tb.sv

//--- sim/pkt_extract_tb.sv
`default_nettype none

`include "pkt_extract_macros.svh"

module pkt_extract_tb;
  timeunit 1ns;
  timeprecision 100ps;

  // ----------------------------------------
  // Run length
  // ----------------------------------------

  localparam int NUM_PKTS   = 40;
  // Tail of the run goes back to back with the slowest ack
  localparam int BURST_PKTS = 16;
  // 40 packets at up to 32 words, 6 ack and 4 overhead cycles each, rounded up
  localparam int MAX_CYCLES = 4000;
  localparam int VAL_W      = $bits(pkt_extract_pkg::mac_out_t);

  // One expected MAC word, last marks the packet end
  typedef struct packed {
    logic                        last;
    logic [`PX_WORD_BYTES-1:0]   valid;
    logic [`PX_WORD_BYTES*8-1:0] data;
  } exp_word_t;

  logic                      i_clk;
  logic                      i_areset;
  pkt_extract_pkg::in_word_t i_in;
  logic                      i_in_valid;
  logic                      o_in_ready;
  pkt_extract_pkg::mac_out_t mac_out;
  logic                      i_mac_ack;

  integer    seed;
  exp_word_t exp_q[$];
  exp_word_t cur;
  logic      holding;
  logic      need_silent;
  logic      ack_max;
  int        stall_seen;
  int        cycle_count;

  pkt_extract_top dut0 (
    .i_clk      (i_clk),
    .i_areset   (i_areset),
    .i_in       (i_in),
    .i_in_valid (i_in_valid),
    .o_in_ready (o_in_ready),
    .o_mac      (mac_out),
    .i_mac_ack  (i_mac_ack)
  );

  always #10 i_clk = ~i_clk;

  // ----------------------------------------
  // Reference model and failure handling
  // ----------------------------------------

  // Bytes swap end for end, lanes past nbytes read as zero
  function automatic exp_word_t expected_out(input pkt_extract_pkg::in_word_t w);
    exp_word_t e;
    e.last  = w.last;
    e.valid = w.last ? 8'hff >> (8 - w.nbytes) : 8'hff;
    for (int b = 0; b < `PX_WORD_BYTES; b++) begin
      e.data[b*8 +: 8] = e.valid[b] ? w.data[63-b*8 -: 8] : 8'h00;
    end
    return e;
  endfunction

  // Whole packets still waiting in the expected queue
  function automatic int pending_packets();
    int n;
    n = 0;
    foreach (exp_q[i]) begin
      n += exp_q[i].last;
    end
    return n;
  endfunction

  task automatic halt_run();
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic flag_mismatch(input string sig, input logic [VAL_W-1:0] exp_v,
                               input logic [VAL_W-1:0] got_v);
    $display("mismatch at %0t ns: %s expected %0h, got %0h", $time, sig, exp_v, got_v);
    halt_run();
  endtask

  task automatic flag_failure(input string what);
    $display("error at %0t ns: %s", $time, what);
    halt_run();
  endtask

  task automatic check_word(input exp_word_t e);
    assert (mac_out.valid == e.valid) else flag_mismatch("o_mac.valid", e.valid, mac_out.valid);
    assert (mac_out.data == e.data) else flag_mismatch("o_mac.data", e.data, mac_out.data);
  endtask

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------

  // Offer one word and wait for the edge that takes it
  task automatic send_word(input pkt_extract_pkg::in_word_t w);
    i_in       = w;
    i_in_valid = 1'b1;
    @(posedge i_clk);
    while (!o_in_ready) begin
      if (ack_max) begin
        stall_seen++;
        // Stall only once every slot holds a packet
        assert (pending_packets() >= `PX_NUM_SLOTS - 1)
          else flag_failure("input stalled while slots were still free");
      end
      @(posedge i_clk);
    end
    exp_q.push_back(expected_out(w));
    #1;
  endtask

  task automatic idle_cycles(input int n);
    i_in_valid = 1'b0;
    repeat (n) @(posedge i_clk);
    #1;
  endtask

  task automatic send_packet(input int len, input int nbytes, input bit gaps);
    pkt_extract_pkg::in_word_t w;
    for (int i = 0; i < len; i++) begin
      w.data   = {$random(seed), $random(seed)};
      w.last   = (i == len - 1);
      // Junk byte count on inner words, the DUT ignores it
      w.nbytes = w.last ? 4'(nbytes) : 4'($random(seed));
      send_word(w);
      if (gaps && ($random(seed) & 3) == 0) begin
        idle_cycles(1 + ($random(seed) & 3));
      end
    end
  endtask

  initial begin : stimulus
    int len;
    int nbytes;
    seed        = 32'h5a88;
    i_clk       = 1'b0;
    i_areset    = 1'b1;
    i_in        = '0;
    i_in_valid  = 1'b0;
    i_mac_ack   = 1'b0;
    holding     = 1'b0;
    need_silent = 1'b0;
    ack_max     = 1'b0;
    stall_seen  = 0;
    cycle_count = 0;
    // Output starts between packets
    cur         = '0;
    cur.last    = 1'b1;
    repeat (5) @(posedge i_clk);
    #1 i_areset = 1'b0;
    // Idle outputs before any input
    @(posedge i_clk);
    assert (mac_out == '0) else flag_mismatch("o_mac", '0, mac_out);
    assert (o_in_ready == 1'b1) else flag_mismatch("o_in_ready", 1, o_in_ready);
    #1;
    for (int p = 0; p < NUM_PKTS; p++) begin
      // First eight packets walk through every byte count
      nbytes = (p < 8) ? p + 1 : 1 + ($unsigned($random(seed)) % 8);
      if (p == 0) begin
        len = 1;
      end else if (p < NUM_PKTS - BURST_PKTS) begin
        len = 1 + ($unsigned($random(seed)) % `PX_SLOT_WORDS);
      end else begin
        len = 24 + ($unsigned($random(seed)) % 9);
      end
      if (p == NUM_PKTS - BURST_PKTS) begin
        ack_max = 1'b1;
      end
      send_packet(len, nbytes, p < NUM_PKTS - BURST_PKTS);
    end
    i_in_valid = 1'b0;
    // Let the transmitter drain
    while (exp_q.size() != 0 || holding) begin
      @(posedge i_clk);
    end
    repeat (4) @(posedge i_clk);
    // Every slot back to free once drained
    assert (o_in_ready == 1'b1) else flag_mismatch("o_in_ready", 1, o_in_ready);
    assert (stall_seen > 0) else flag_failure("input never stalled with all slots occupied");
    $display("No errors");
    $finish;
  end

  // ----------------------------------------
  // MAC ack responder
  // ----------------------------------------

  initial begin : ack_responder
    int delay;
    forever begin
      @(posedge i_clk);
      if (!i_areset && mac_out.start) begin
        delay = ack_max ? 5 : $unsigned($random(seed)) % 6;
        repeat (delay) @(posedge i_clk);
        #1 i_mac_ack = 1'b1;
        @(posedge i_clk);
        #1 i_mac_ack = 1'b0;
      end
    end
  end

  // ----------------------------------------
  // Comparator and timeout
  // ----------------------------------------

  always @(posedge i_clk) begin
    if (!i_areset) begin
      if (need_silent) begin
        // One empty cycle after every packet
        assert (mac_out == '0) else flag_mismatch("o_mac after last word", '0, mac_out);
        need_silent = 1'b0;
      end else if (holding) begin
        // Word 0 parked on the port until the ack
        assert (!mac_out.start) else flag_failure("start held for more than one cycle");
        check_word(cur);
        if (i_mac_ack) begin
          holding     = 1'b0;
          need_silent = cur.last;
        end
      end else if (mac_out.start) begin
        // A packet opens only after the previous one closed
        assert (cur.last) else flag_failure("start pulse inside a packet");
        assert (exp_q.size() != 0) else flag_failure("start with no packet pending");
        cur = exp_q.pop_front();
        check_word(cur);
        holding = 1'b1;
      end else if (mac_out.valid != '0) begin
        // Only the start pulse may open a packet
        assert (!cur.last) else flag_failure("packet word without a start pulse");
        assert (exp_q.size() != 0) else flag_failure("output word with no input pending");
        cur = exp_q.pop_front();
        check_word(cur);
        need_silent = cur.last;
      end else begin
        assert (mac_out.data == '0) else flag_mismatch("o_mac.data", '0, mac_out.data);
      end
    end
  end

  always @(posedge i_clk) begin
    cycle_count++;
    // Bound checker keeps its own tally
    assert (dut0.asrt0.fail_count == 0) else flag_failure("bound protocol assertion failed");
    if (cycle_count >= MAX_CYCLES) begin
      $display("timeout: run still busy after %0d cycles", MAX_CYCLES);
      halt_run();
    end
  end

endmodule

`default_nettype wire

//--- sim/pkt_extract_assertions.sv
`default_nettype none

`include "pkt_extract_macros.svh"

module pkt_extract_assertions (
  input  logic                        i_clk,
  input  logic                        i_areset,
  input  pkt_extract_pkg::in_word_t   i_in,
  input  logic                        i_in_valid,
  input  logic                        i_in_ready,
  input  pkt_extract_pkg::mac_out_t   i_mac,
  input  pkt_extract_pkg::slot_wr_t   i_wr,
  input  logic [`PX_NUM_SLOTS-1:0]    i_wr_en,
  input  logic [`PX_NUM_SLOTS-1:0]    i_slot_loaded
);
  timeunit 1ns;
  timeprecision 100ps;

  // Failed assertions so far, polled by the testbench
  int fail_count = 0;

  // ----------------------------------------
  // Input stream
  // ----------------------------------------

  // Sender keeps word and valid steady through a stall
  assert property (@(posedge i_clk) disable iff (i_areset)
    (i_in_valid && !i_in_ready) |=> (i_in_valid && $stable(i_in)))
    else begin
      $error("input word or valid changed while ready was low");
      fail_count++;
    end

  // ----------------------------------------
  // Slots and MAC port
  // ----------------------------------------

  // Start pulse never stretches
  assert property (@(posedge i_clk) disable iff (i_areset) i_mac.start |=> !i_mac.start)
    else begin
      $error("start stayed high for more than one cycle");
      fail_count++;
    end

  // A loaded slot takes no writes until it is released
  assert property (@(posedge i_clk) disable iff (i_areset) (i_wr_en & i_slot_loaded) == '0)
    else begin
      $error("write enable reached a loaded slot");
      fail_count++;
    end

  // Top word address must close the packet, so nothing wraps
  assert property (@(posedge i_clk) disable iff (i_areset)
    (|i_wr_en && i_wr.addr == `PX_SLOT_AW'(`PX_SLOT_WORDS - 1)) |-> i_wr.word.last)
    else begin
      $error("packet longer than one slot");
      fail_count++;
    end

endmodule

bind pkt_extract_top pkt_extract_assertions asrt0 (
  .i_clk         (i_clk),
  .i_areset      (i_areset),
  .i_in          (i_in),
  .i_in_valid    (i_in_valid),
  .i_in_ready    (o_in_ready),
  .i_mac         (o_mac),
  .i_wr          (wr),
  .i_wr_en       (wr_en),
  .i_slot_loaded (slot_loaded)
);

`default_nettype wire

//--- verilog/pkt_extract_top.sv
`default_nettype none

`include "pkt_extract_macros.svh"

module pkt_extract_top (
  input  logic                          i_clk,
  input  logic                          i_areset,

  // Packet input stream
  input  pkt_extract_pkg::in_word_t     i_in,
  input  logic                          i_in_valid,
  output logic                          o_in_ready,

  // MAC transmit port
  output pkt_extract_pkg::mac_out_t     o_mac,
  input  logic                          i_mac_ack
);

  // Capture to slots
  pkt_extract_pkg::slot_wr_t                             wr;
  logic [`PX_NUM_SLOTS-1:0]                              wr_en;
  logic [`PX_NUM_SLOTS-1:0]                              slot_free;

  // Slots to transmitter
  logic [`PX_NUM_SLOTS-1:0]                              slot_loaded;
  logic [`PX_NUM_SLOTS-1:0][`PX_SLOT_AW:0]               slot_len;
  logic [`PX_NUM_SLOTS-1:0][3:0]                         slot_last_bytes;
  logic [`PX_NUM_SLOTS-1:0][`PX_WORD_BYTES*8-1:0]        slot_rd_data;
  logic [`PX_SLOT_AW-1:0]                                rd_addr;
  logic [`PX_NUM_SLOTS-1:0]                              slot_release;

  // ----------------------------------------
  // Input side
  // ----------------------------------------

  pkt_capture cap0 (
    .i_clk       (i_clk),
    .i_areset    (i_areset),
    .i_in        (i_in),
    .i_in_valid  (i_in_valid),
    .o_in_ready  (o_in_ready),
    .i_slot_free (slot_free),
    .o_wr        (wr),
    .o_wr_en     (wr_en)
  );

  // ----------------------------------------
  // Slot ring
  // ----------------------------------------

  for (genvar k = 0; k < `PX_NUM_SLOTS; k++) begin : slot_gen
    pkt_slot slot0 (
      .i_clk        (i_clk),
      .i_areset     (i_areset),
      .i_wr         (wr),
      .i_wr_en      (wr_en[k]),
      .i_rd_addr    (rd_addr),
      .i_release    (slot_release[k]),
      .o_free       (slot_free[k]),
      .o_loaded     (slot_loaded[k]),
      .o_len        (slot_len[k]),
      .o_last_bytes (slot_last_bytes[k]),
      .o_rd_data    (slot_rd_data[k])
    );
  end

  // ----------------------------------------
  // Output side
  // ----------------------------------------

  mac_tx tx0 (
    .i_clk        (i_clk),
    .i_areset     (i_areset),
    .i_loaded     (slot_loaded),
    .i_len        (slot_len),
    .i_last_bytes (slot_last_bytes),
    .i_rd_data    (slot_rd_data),
    .o_rd_addr    (rd_addr),
    .o_release    (slot_release),
    .o_mac        (o_mac),
    .i_mac_ack    (i_mac_ack)
  );

endmodule

`default_nettype wire

//--- verilog/mac_tx.sv
`default_nettype none

`include "pkt_extract_macros.svh"

module mac_tx (
  input  logic                                            i_clk,
  input  logic                                            i_areset,

  // Slot status and read data
  input  logic [`PX_NUM_SLOTS-1:0]                        i_loaded,
  input  logic [`PX_NUM_SLOTS-1:0][`PX_SLOT_AW:0]         i_len,
  input  logic [`PX_NUM_SLOTS-1:0][3:0]                   i_last_bytes,
  input  logic [`PX_NUM_SLOTS-1:0][`PX_WORD_BYTES*8-1:0]  i_rd_data,
  output logic [`PX_SLOT_AW-1:0]                          o_rd_addr,
  output logic [`PX_NUM_SLOTS-1:0]                        o_release,

  // MAC start/ack port
  output pkt_extract_pkg::mac_out_t                       o_mac,
  input  logic                                            i_mac_ack
);

  typedef enum logic [2:0] {
    TX_IDLE,
    TX_FETCH,
    TX_AWAIT_ACK,
    TX_STREAM,
    TX_SILENT
  } tx_state_e;

  tx_state_e                   state;
  // Slot being drained
  logic [`PX_SLOT_SEL_W-1:0]   rd_ptr;
  // Word index whose data sits on i_rd_data this cycle
  logic [`PX_SLOT_AW-1:0]      addr_q;
  logic [`PX_SLOT_AW:0]        cur_len;
  logic                        is_last;
  logic [`PX_WORD_BYTES-1:0]   cur_mask;
  logic [`PX_WORD_BYTES*8-1:0] cur_data;

  // Low nbytes bits set
  function automatic logic [`PX_WORD_BYTES-1:0] last_mask(input logic [3:0] nbytes);
    logic [`PX_WORD_BYTES-1:0] m;
    for (int i = 0; i < `PX_WORD_BYTES; i++) begin
      m[i] = (i < nbytes);
    end
    return m;
  endfunction

  // Output byte i takes input byte 7-i, cleared where the mask is low
  function automatic logic [`PX_WORD_BYTES*8-1:0] byte_reverse(
    input logic [`PX_WORD_BYTES*8-1:0] d,
    input logic [`PX_WORD_BYTES-1:0]   v
  );
    logic [`PX_WORD_BYTES*8-1:0] r;
    for (int i = 0; i < `PX_WORD_BYTES; i++) begin
      r[8*i +: 8] = v[i] ? d[8*(`PX_WORD_BYTES-1-i) +: 8] : 8'h00;
    end
    return r;
  endfunction

  // ----------------------------------------
  // Current word and its mask
  // ----------------------------------------

  assign cur_len  = i_len[rd_ptr];
  assign is_last  = ({1'b0, addr_q} == cur_len - 1'b1);
  assign cur_mask = is_last ? last_mask(i_last_bytes[rd_ptr]) : '1;
  assign cur_data = byte_reverse(i_rd_data[rd_ptr], cur_mask);

  // Slot goes back to free on the edge that leaves the silent state
  assign o_release = (state == TX_SILENT) ? (`PX_NUM_SLOTS'(1) << rd_ptr) : '0;

  // Read address runs one word ahead of the output register
  // Held on word 1 until the MAC acks
  always_comb begin
    case (state)
      TX_FETCH:     o_rd_addr = addr_q + 1'b1;
      TX_AWAIT_ACK: o_rd_addr = i_mac_ack ? addr_q + 1'b1 : addr_q;
      TX_STREAM:    o_rd_addr = addr_q + 1'b1;
      default:      o_rd_addr = '0;
    endcase
  end

  // ----------------------------------------
  // Transmit FSM
  // ----------------------------------------

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      state  <= TX_IDLE;
      rd_ptr <= '0;
      addr_q <= '0;
      o_mac  <= '0;
    end else begin
      addr_q <= o_rd_addr;
      case (state)
        TX_IDLE: begin
          // Word 0 is read during the fetch cycle
          if (i_loaded[rd_ptr]) begin
            state <= TX_FETCH;
          end
        end
        TX_FETCH: begin
          o_mac.start <= 1'b1;
          o_mac.valid <= cur_mask;
          o_mac.data  <= cur_data;
          state       <= TX_AWAIT_ACK;
        end
        TX_AWAIT_ACK: begin
          // Word 0 stays on the port, start only for one cycle
          o_mac.start <= 1'b0;
          if (i_mac_ack) begin
            if (cur_len == (`PX_SLOT_AW+1)'(1)) begin
              // Single-word packet already sent
              o_mac <= '0;
              state <= TX_SILENT;
            end else begin
              o_mac.valid <= cur_mask;
              o_mac.data  <= cur_data;
              state       <= is_last ? TX_SILENT : TX_STREAM;
            end
          end
        end
        TX_STREAM: begin
          // No back-pressure after ack
          o_mac.valid <= cur_mask;
          o_mac.data  <= cur_data;
          if (is_last) begin
            state <= TX_SILENT;
          end
        end
        TX_SILENT: begin
          // Zero word marks the packet end for the MAC
          o_mac  <= '0;
          rd_ptr <= rd_ptr + 1'b1;
          state  <= TX_IDLE;
        end
        default: begin
          o_mac <= '0;
          state <= TX_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- verilog/pkt_slot.sv
`default_nettype none

`include "pkt_extract_macros.svh"

module pkt_slot (
  input  logic                             i_clk,
  input  logic                             i_areset,

  // Write side, from capture
  input  pkt_extract_pkg::slot_wr_t        i_wr,
  input  logic                             i_wr_en,

  // Read side, from the transmitter
  input  logic [`PX_SLOT_AW-1:0]           i_rd_addr,
  input  logic                             i_release,

  output logic                             o_free,
  output logic                             o_loaded,
  output logic [`PX_SLOT_AW:0]             o_len,
  output logic [3:0]                       o_last_bytes,
  output logic [`PX_WORD_BYTES*8-1:0]      o_rd_data
);

  typedef enum logic [1:0] {
    ST_FREE,
    ST_FILLING,
    ST_LOADED
  } slot_state_e;

  slot_state_e state;

  // Word storage for one packet
  logic [`PX_WORD_BYTES*8-1:0] mem [0:`PX_SLOT_WORDS-1];

  assign o_free   = (state == ST_FREE);
  assign o_loaded = (state == ST_LOADED);

  // ----------------------------------------
  // Storage, registered read
  // ----------------------------------------

  always_ff @(posedge i_clk) begin
    if (i_wr_en) begin
      mem[i_wr.addr] <= i_wr.word.data;
    end
    o_rd_data <= mem[i_rd_addr];
  end

  // ----------------------------------------
  // Slot state, length and byte count
  // ----------------------------------------

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      state        <= ST_FREE;
      o_len        <= '0;
      o_last_bytes <= '0;
    end else if (i_release) begin
      // Transmitter is done with this packet
      state <= ST_FREE;
      o_len <= '0;
    end else if (i_wr_en && state != ST_LOADED) begin
      // First word restarts the count
      o_len <= (state == ST_FREE) ? (`PX_SLOT_AW+1)'(1) : o_len + 1'b1;
      if (i_wr.word.last) begin
        o_last_bytes <= i_wr.word.nbytes;
        state        <= ST_LOADED;
      end else begin
        state <= ST_FILLING;
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/pkt_capture.sv
`default_nettype none

`include "pkt_extract_macros.svh"

module pkt_capture (
  input  logic                             i_clk,
  input  logic                             i_areset,

  // Input word stream
  input  pkt_extract_pkg::in_word_t        i_in,
  input  logic                             i_in_valid,
  output logic                             o_in_ready,

  // Slot side
  input  logic [`PX_NUM_SLOTS-1:0]         i_slot_free,
  output pkt_extract_pkg::slot_wr_t        o_wr,
  output logic [`PX_NUM_SLOTS-1:0]         o_wr_en
);

  // Slot currently being filled
  logic [`PX_SLOT_SEL_W-1:0] fill_ptr;
  // Address of the next word inside that slot
  logic [`PX_SLOT_AW-1:0]    wr_addr;
  logic                      accept;

  // ----------------------------------------
  // Input handshake
  // ----------------------------------------

  // A nonzero word address means the slot is already ours mid-packet
  // Otherwise the slot must be free before a new packet may begin
  assign o_in_ready = i_slot_free[fill_ptr] | (wr_addr != '0);
  assign accept     = i_in_valid & o_in_ready;

  // ----------------------------------------
  // Fill pointer and word address
  // ----------------------------------------

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      fill_ptr <= '0;
      wr_addr  <= '0;
      o_wr_en  <= '0;
    end else begin
      // Enable is a one-cycle pulse per accepted word
      o_wr_en <= '0;
      if (accept) begin
        o_wr_en <= `PX_NUM_SLOTS'(1) << fill_ptr;
        if (i_in.last) begin
          // Packet complete, next packet goes to the following slot
          // The slot marks itself loaded when this word lands
          wr_addr  <= '0;
          fill_ptr <= fill_ptr + 1'b1;
        end else begin
          wr_addr <= wr_addr + 1'b1;
        end
      end
    end
  end

  // ----------------------------------------
  // Write bus payload
  // ----------------------------------------

  // Registered copy of the accepted word, valid alongside o_wr_en
  always_ff @(posedge i_clk) begin
    if (accept) begin
      o_wr.addr <= wr_addr;
      o_wr.word <= i_in;
    end
  end

endmodule

`default_nettype wire

//--- verilog/pkt_extract_pkg.sv
`default_nettype none

`include "pkt_extract_macros.svh"

package pkt_extract_pkg;

  // ----------------------------------------
  // Input stream word
  // ----------------------------------------

  // One word of the input stream
  // nbytes only matters on the final word
  typedef struct packed {
    logic [`PX_WORD_BYTES*8-1:0] data;
    logic                        last;
    logic [3:0]                  nbytes;
  } in_word_t;

  // ----------------------------------------
  // Slot write bus
  // ----------------------------------------

  // Shared by all slots, the per-slot enables run beside it
  typedef struct packed {
    logic [`PX_SLOT_AW-1:0] addr;
    in_word_t               word;
  } slot_wr_t;

  // ----------------------------------------
  // MAC transmit port
  // ----------------------------------------

  // Start pulse, byte valid mask and byte-reversed data
  typedef struct packed {
    logic                        start;
    logic [`PX_WORD_BYTES-1:0]   valid;
    logic [`PX_WORD_BYTES*8-1:0] data;
  } mac_out_t;

endpackage

`default_nettype wire

//--- include/pkt_extract_macros.svh
`ifndef PKT_EXTRACT_MACROS_SVH
`define PKT_EXTRACT_MACROS_SVH

// ----------------------------------------
// Slot ring geometry
// ----------------------------------------

// Number of packet slots, kept a power of two so pointers wrap by themselves
`define PX_NUM_SLOTS 4
// Width of a slot pointer
`define PX_SLOT_SEL_W 2

// Words held by one slot, and the address width inside a slot
`define PX_SLOT_WORDS 32
`define PX_SLOT_AW 5

// ----------------------------------------
// Stream word geometry
// ----------------------------------------

// Bytes per 64-bit word, also the width of the byte valid mask
`define PX_WORD_BYTES 8

`endif
